//--- tb.f
rtl/uart_pkg.sv
rtl/byte_fifo.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/uart_regs.sv
rtl/uart_top.sv
testbench/tb_clock.sv
testbench/tb_uart.sv

//--- testbench/tb_uart.sv
// Testbench for uart_top; drives bus and serial line, decodes tx_o and checks against a model.
`default_nettype none

module tb_uart;

    localparam int LIMIT = 40 * 12 * 33 + 20000;       // Longest frame budget plus margin.
    localparam int DEPTH = uart_pkg::FIFO_DEPTH;

    logic               clk;
    logic               rst;
    uart_pkg::bus_req_t bus;
    logic [15:0]        rdata;
    logic               rx_line;
    logic               rx_drv;
    logic               loop_sel;
    logic               tx_line;

    logic [31:0] seed;
    logic [15:0] mon_div;
    logic        mon_prev;
    int          cycles;
    logic [7:0]  exp_tx[$];
    logic [8:0]  exp_rx[$];
    logic        exp_overrun;
    int          order[5];

    tb_clock u_clock (
        .clk_o (clk),
        .rst_o (rst)
    );

    uart_top dut (
        .clk_i   (clk),
        .rst_i   (rst),
        .bus_i   (bus),
        .rdata_o (rdata),
        .rx_i    (rx_line),
        .tx_o    (tx_line)
    );

    assign rx_line = loop_sel ? tx_line : rx_drv;      // Loopback or serial driver.

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return {16'h0000, seed[31:16]};                // Upper bits have the longer period.
    endfunction

    function automatic logic [15:0] status_word(input logic tx_empty, input logic tx_full,
                                                input logic rx_empty, input logic rx_full,
                                                input logic overrun, input logic busy);
        return {10'b0, busy, overrun, rx_full, rx_empty, tx_full, tx_empty};
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1, "Run stopped at the first error.");
    endtask

    task automatic check_value(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        assert (expected === actual) else begin
            abort_run($sformatf("FAIL %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    task automatic bus_write(input logic [1:0] addr, input logic [15:0] data);
        @(negedge clk);
        bus.addr  = addr;
        bus.wdata = data;
        bus.we    = 1'b1;
        @(negedge clk);
        bus.we = 1'b0;
    endtask

    task automatic bus_read(input logic [1:0] addr, output logic [15:0] data);
        @(negedge clk);
        bus.addr = addr;
        bus.re   = 1'b1;
        @(negedge clk);
        bus.re = 1'b0;
        data   = rdata;                                // Registered one clock after the strobe.
    endtask

    task automatic check_read(input string name, input logic [1:0] addr,
                              input logic [15:0] expected);
        logic [15:0] got;
        bus_read(addr, got);
        check_value(name, expected, got);
    endtask

    task automatic model_rx_push(input logic [8:0] entry);
        if (exp_rx.size() < DEPTH) begin
            exp_rx.push_back(entry);
        end else begin
            exp_overrun = 1'b1;                        // Newest character is lost.
        end
    endtask

    task automatic read_data_check(input string name);
        logic [15:0] expected;
        expected = 16'h0000;
        if (exp_rx.size() > 0) begin
            expected = {7'b0, exp_rx.pop_front()};
        end
        check_read(name, uart_pkg::ADDR_DATA, expected);
    endtask

    task automatic write_byte(input logic [7:0] b);
        bus_write(uart_pkg::ADDR_DATA, {8'h00, b});
        if (exp_tx.size() < DEPTH) begin
            exp_tx.push_back(b);
        end
    endtask

    // Polls STATUS until the queue is empty (bit 0) and the transmitter is idle (bit 5).
    task automatic wait_tx_idle();
        logic [15:0] st;
        st = 16'h0000;
        while (!(st[0] && !st[5])) begin
            bus_read(uart_pkg::ADDR_STATUS, st);
        end
        check_value("frames still expected", 16'd0, 16'(exp_tx.size()));
    endtask

    task automatic drive_bit(input logic b);
        rx_drv = b;
        repeat (mon_div + 1) @(negedge clk);
    endtask

    task automatic send_serial(input logic [7:0] data, input logic stop);
        @(negedge clk);
        drive_bit(1'b0);
        for (int i = 0; i < 8; i++) begin
            drive_bit(data[i]);
        end
        drive_bit(stop);
        drive_bit(1'b1);                               // Idle period so the receiver rearms.
        model_rx_push({!stop, data});
    endtask

    task automatic prepare(input logic [15:0] div, input logic loop);
        loop_sel = loop;
        bus_write(uart_pkg::ADDR_BAUD, div);
        mon_div = div;
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= LIMIT) begin
            abort_run("Timeout: the run went past its cycle limit.");
        end
    end

    // Decodes tx_o at mid-bit with the current divisor.
    always begin : line_monitor
        logic [7:0] got;
        logic [7:0] expected;
        int         p;
        @(negedge clk);
        if (!rst && mon_prev && !tx_line) begin
            p = mon_div + 1;
            repeat (p / 2) @(negedge clk);
            assert (!tx_line) else abort_run("Start bit on tx_o did not stay low.");
            for (int i = 0; i < 8; i++) begin
                repeat (p) @(negedge clk);
                got[i] = tx_line;
            end
            for (int i = 0; i < uart_pkg::TX_STOP_BITS; i++) begin
                repeat (p) @(negedge clk);
                assert (tx_line) else abort_run("A stop period on tx_o was low.");
            end
            assert (exp_tx.size() > 0) else abort_run("A frame appeared with no byte queued.");
            expected = exp_tx.pop_front();
            check_value("tx frame", {8'h00, expected}, {8'h00, got});
            if (loop_sel) begin
                model_rx_push({1'b0, expected});
            end
        end
        mon_prev = tx_line;
    end

    task automatic check_reset_values();
        check_read("reset status", uart_pkg::ADDR_STATUS, status_word(1, 0, 1, 0, 0, 0));
        check_read("reset baud", uart_pkg::ADDR_BAUD, 16'd15);
        check_read("reset ctrl", uart_pkg::ADDR_CTRL, 16'd0);
        check_value("reset tx line", 16'd1, {15'b0, tx_line});
    endtask

    task automatic transmit_burst();
        prepare(16'd15, 1'b0);
        repeat (12) begin
            write_byte(8'(next_rand()));
            repeat (next_rand() % 40) @(negedge clk);
        end
        wait_tx_idle();
    endtask

    task automatic loopback_receive();
        int n;
        prepare(16'd15, 1'b1);
        n = 4 + next_rand() % 5;
        repeat (n) write_byte(8'(next_rand()));
        wait_tx_idle();
        repeat (n) read_data_check("loopback data");
        read_data_check("loopback empty read");
        check_read("loopback status", uart_pkg::ADDR_STATUS, status_word(1, 0, 1, 0, 0, 0));
    endtask

    task automatic stall_and_full();
        prepare(16'd15, 1'b0);
        bus_write(uart_pkg::ADDR_CTRL, 16'd1);
        repeat (DEPTH + 1) write_byte(8'(next_rand()));
        check_read("stall status", uart_pkg::ADDR_STATUS, status_word(0, 1, 1, 0, 0, 0));
        repeat (3 * 16) begin
            @(negedge clk);
            assert (tx_line) else abort_run("tx_o left idle while the transmitter was stalled.");
        end
        bus_write(uart_pkg::ADDR_CTRL, 16'd0);
        // The first frame has started and its byte is still queued.
        repeat (2 * 16) @(negedge clk);
        check_read("sending status", uart_pkg::ADDR_STATUS, status_word(0, 1, 1, 0, 0, 1));
        wait_tx_idle();
    endtask

    task automatic frame_error_overrun();
        prepare(16'd15, 1'b0);
        send_serial(8'(next_rand()), 1'b0);
        read_data_check("frame error data");
        repeat (DEPTH + 1) begin
            send_serial(8'(next_rand()), 1'b1);
            repeat (next_rand() % 20) @(negedge clk);
        end
        check_read("overrun status", uart_pkg::ADDR_STATUS,
                   status_word(1, 0, 0, 1, exp_overrun, 0));
        exp_overrun = 1'b0;                            // STATUS read clears the sticky flag.
        check_read("overrun cleared", uart_pkg::ADDR_STATUS,
                   status_word(1, 0, 0, 1, exp_overrun, 0));
        repeat (DEPTH) read_data_check("overrun data");
        read_data_check("overrun empty read");
    endtask

    task automatic baud_change();
        prepare(16'd7, 1'b1);
        check_read("baud readback", uart_pkg::ADDR_BAUD, 16'd7);
        write_byte(8'(next_rand()));
        wait_tx_idle();
        read_data_check("baud change data");
    endtask

    initial begin
        int pick;
        int tmp;
        seed        = 32'h8582;
        bus         = '0;
        rx_drv      = 1'b1;
        loop_sel    = 1'b0;
        mon_div     = 16'd15;
        mon_prev    = 1'b1;
        cycles      = 0;
        exp_overrun = 1'b0;
        order       = '{2, 3, 4, 5, 6};
        @(negedge clk);
        while (rst) @(negedge clk);
        check_reset_values();
        for (int i = 4; i > 0; i--) begin
            pick        = next_rand() % (i + 1);
            tmp         = order[i];
            order[i]    = order[pick];
            order[pick] = tmp;
        end
        foreach (order[i]) begin
            case (order[i])
                2:       transmit_burst();
                3:       loopback_receive();
                4:       stall_and_full();
                5:       frame_error_overrun();
                default: baud_change();
            endcase
        end
        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/tb_clock.sv
// Clock and reset source for the UART testbench; 10 unit period, reset held for 5 cycles.
`default_nettype none

module tb_clock (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;
    end

    initial begin
        rst_o = 1'b1;
        repeat (5) @(posedge clk_o);
        @(negedge clk_o);
        rst_o = 1'b0;                                  // Released away from the active edge.
    end

endmodule

`default_nettype wire

//--- rtl/uart_top.sv
// Top level of the UART peripheral; connects the bus registers, both queues and both serializers.
`default_nettype none

module uart_top (
    input  wire logic               clk_i,
    input  wire logic               rst_i,
    input  wire uart_pkg::bus_req_t bus_i,
    output logic [15:0]             rdata_o,
    input  wire logic               rx_i,
    output logic                    tx_o
);

    logic [uart_pkg::BAUD_W-1:0] baud_div;
    logic                        stall;

    logic       txq_push;
    logic [7:0] txq_data;
    logic       txq_pop;
    logic [7:0] txq_head;
    logic       txq_empty;
    logic       txq_full;
    logic       tx_busy;

    uart_pkg::rx_entry_t rxq_data;
    uart_pkg::rx_entry_t rxq_head;
    logic                rxq_push;
    logic                rxq_pop;
    logic                rxq_empty;
    logic                rxq_full;

    uart_regs u_regs (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .bus_i       (bus_i),
        .rdata_o     (rdata_o),
        .txq_push_o  (txq_push),
        .txq_data_o  (txq_data),
        .txq_empty_i (txq_empty),
        .txq_full_i  (txq_full),
        .tx_busy_i   (tx_busy),
        .rxq_pop_o   (rxq_pop),
        .rxq_head_i  (rxq_head),
        .rxq_empty_i (rxq_empty),
        .rxq_full_i  (rxq_full),
        .rxq_push_i  (rxq_push),
        .baud_div_o  (baud_div),
        .stall_o     (stall)
    );

    byte_fifo #(.entry_t(logic [7:0])) u_tx_fifo (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .push_i      (txq_push),
        .push_data_i (txq_data),
        .pop_i       (txq_pop),
        .head_o      (txq_head),
        .empty_o     (txq_empty),
        .full_o      (txq_full)
    );

    byte_fifo #(.entry_t(uart_pkg::rx_entry_t)) u_rx_fifo (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .push_i      (rxq_push),
        .push_data_i (rxq_data),
        .pop_i       (rxq_pop),
        .head_o      (rxq_head),
        .empty_o     (rxq_empty),
        .full_o      (rxq_full)
    );

    uart_tx u_tx (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .baud_div_i (baud_div),
        .stall_i    (stall),
        .q_empty_i  (txq_empty),
        .q_head_i   (txq_head),
        .q_pop_o    (txq_pop),
        .busy_o     (tx_busy),
        .tx_o       (tx_o)
    );

    uart_rx u_rx (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .baud_div_i (baud_div),
        .rx_i       (rx_i),
        .push_o     (rxq_push),
        .entry_o    (rxq_data)
    );

endmodule

`default_nettype wire

//--- rtl/uart_regs.sv
// Register block of the UART; turns bus strobes into queue traffic and holds baud and control.
`default_nettype none

module uart_regs (
    input  wire logic                        clk_i,
    input  wire logic                        rst_i,
    input  wire uart_pkg::bus_req_t          bus_i,
    output logic [15:0]                      rdata_o,
    output logic                             txq_push_o,
    output logic [7:0]                       txq_data_o,
    input  wire logic                        txq_empty_i,
    input  wire logic                        txq_full_i,
    input  wire logic                        tx_busy_i,
    output logic                             rxq_pop_o,
    input  wire uart_pkg::rx_entry_t         rxq_head_i,
    input  wire logic                        rxq_empty_i,
    input  wire logic                        rxq_full_i,
    input  wire logic                        rxq_push_i,
    output logic [uart_pkg::BAUD_W-1:0]      baud_div_o,
    output logic                             stall_o
);

    uart_pkg::status_t status;

    logic rd_data;
    logic rd_status;
    logic wr_data;
    logic wr_baud;
    logic wr_ctrl;
    logic overrun;

    assign wr_data   = bus_i.we && (bus_i.addr == uart_pkg::ADDR_DATA);
    assign wr_baud   = bus_i.we && (bus_i.addr == uart_pkg::ADDR_BAUD);
    assign wr_ctrl   = bus_i.we && (bus_i.addr == uart_pkg::ADDR_CTRL);
    assign rd_data   = bus_i.re && (bus_i.addr == uart_pkg::ADDR_DATA);
    assign rd_status = bus_i.re && (bus_i.addr == uart_pkg::ADDR_STATUS);

    assign txq_push_o = wr_data && !txq_full_i;        // A write to a full queue is dropped.
    assign txq_data_o = bus_i.wdata[7:0];
    assign rxq_pop_o  = rd_data && !rxq_empty_i;

    always_comb begin
        status            = '0;
        status.tx_empty   = txq_empty_i;
        status.tx_full    = txq_full_i;
        status.rx_empty   = rxq_empty_i;
        status.rx_full    = rxq_full_i;
        status.rx_overrun = overrun;
        status.tx_busy    = tx_busy_i;
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            baud_div_o <= uart_pkg::BAUD_RESET;
            stall_o    <= 1'b0;
            overrun    <= 1'b0;
        end else begin
            if (wr_baud) begin
                baud_div_o <= bus_i.wdata[uart_pkg::BAUD_W-1:0];
            end
            if (wr_ctrl) begin
                stall_o <= bus_i.wdata[0];
            end
            // A character lost in this cycle wins over the clear.
            if (rxq_push_i && rxq_full_i) begin
                overrun <= 1'b1;
            end else if (rd_status) begin
                overrun <= 1'b0;
            end
        end
    end

    // Read data appears one clock after the strobe and holds until the next read.
    always_ff @(posedge clk_i) begin
        if (bus_i.re) begin
            case (bus_i.addr)
                uart_pkg::ADDR_DATA:   rdata_o <= rxq_empty_i ? 16'h0000 : {7'b0, rxq_head_i};
                uart_pkg::ADDR_STATUS: rdata_o <= status;
                uart_pkg::ADDR_BAUD:   rdata_o <= baud_div_o;
                default:               rdata_o <= {15'b0, stall_o};
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/uart_rx.sv
// UART receive deserializer; samples each bit at mid-period and pushes bytes with a frame error flag.
`default_nettype none

module uart_rx (
    input  wire logic                        clk_i,
    input  wire logic                        rst_i,
    input  wire logic [uart_pkg::BAUD_W-1:0] baud_div_i,
    input  wire logic                        rx_i,
    output logic                             push_o,
    output uart_pkg::rx_entry_t              entry_o
);

    typedef enum logic [2:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP,
        RX_WAIT_HIGH
    } rx_state_t;

    rx_state_t                   state;
    logic [uart_pkg::BAUD_W-1:0] cnt;
    logic [uart_pkg::BAUD_W-1:0] half_div;
    logic [2:0]                  bit_cnt;
    logic [7:0]                  shift_q;

    logic rx_meta;
    logic rx_sync;
    logic rx_prev;
    logic period_done;

    assign half_div    = baud_div_i >> 1;
    assign period_done = (cnt == baud_div_i);

    // Two-flop synchronizer plus one more flop for edge detection.
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx_i;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state   <= RX_IDLE;
            cnt     <= '0;
            bit_cnt <= '0;
        end else begin
            case (state)
                RX_IDLE: begin
                    cnt <= '0;
                    if (rx_prev && !rx_sync) begin
                        state <= RX_START;             // Falling edge of a start bit.
                    end
                end
                RX_START: begin
                    if (cnt == half_div) begin
                        cnt     <= '0;
                        bit_cnt <= '0;
                        state   <= rx_sync ? RX_IDLE : RX_DATA;  // Glitches are discarded.
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (period_done) begin
                        cnt <= '0;
                        if (bit_cnt == 3'd7) begin
                            state <= RX_STOP;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (period_done) begin
                        cnt   <= '0;
                        state <= rx_sync ? RX_IDLE : RX_WAIT_HIGH;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                RX_WAIT_HIGH: begin
                    if (rx_sync) begin
                        state <= RX_IDLE;              // Rearm only once the line is back high.
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // Data arrives LSB first.
    always_ff @(posedge clk_i) begin
        if (state == RX_DATA && period_done) begin
            shift_q <= {rx_sync, shift_q[7:1]};
        end
    end

    assign push_o            = (state == RX_STOP) && period_done;
    assign entry_o.data      = shift_q;
    assign entry_o.frame_err = !rx_sync;               // A low stop bit is a framing error.

endmodule

`default_nettype wire

//--- rtl/uart_tx.sv
// UART transmit serializer; pops the transmit queue and sends 8N frames LSB first on tx_o.
`default_nettype none

module uart_tx (
    input  wire logic                        clk_i,
    input  wire logic                        rst_i,
    input  wire logic [uart_pkg::BAUD_W-1:0] baud_div_i,
    input  wire logic                        stall_i,
    input  wire logic                        q_empty_i,
    input  wire logic [7:0]                  q_head_i,
    output logic                             q_pop_o,
    output logic                             busy_o,
    output logic                             tx_o
);

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_t;

    localparam logic [2:0] LAST_STOP = 3'(uart_pkg::TX_STOP_BITS - 1);

    tx_state_t                   state;
    logic [2:0]                  bit_cnt;              // Data bit index, then stop period count.
    logic [uart_pkg::BAUD_W-1:0] baud_cnt;
    logic                        tick;

    // One tick every baud_div_i + 1 clocks. The compare also recovers after a smaller divisor.
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            baud_cnt <= '0;
            tick     <= 1'b0;
        end else if (baud_cnt >= baud_div_i) begin
            baud_cnt <= '0;
            tick     <= 1'b1;
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
            tick     <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state   <= TX_IDLE;
            bit_cnt <= '0;
        end else if (tick) begin
            case (state)
                TX_IDLE: begin
                    if (!q_empty_i && !stall_i) begin
                        state <= TX_START;             // Stall only holds off a new frame.
                    end
                end
                TX_START: begin
                    state   <= TX_DATA;
                    bit_cnt <= '0;
                end
                TX_DATA: begin
                    if (bit_cnt == 3'd7) begin
                        state   <= TX_STOP;
                        bit_cnt <= '0;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                TX_STOP: begin
                    if (bit_cnt == LAST_STOP) begin
                        state   <= TX_IDLE;
                        bit_cnt <= '0;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    // The byte leaves the queue on the tick that ends the last stop period.
    assign q_pop_o = tick && (state == TX_STOP) && (bit_cnt == LAST_STOP);
    assign busy_o  = (state != TX_IDLE);

    always_comb begin
        case (state)
            TX_START: tx_o = 1'b0;
            TX_DATA:  tx_o = q_head_i[bit_cnt];        // Head stays put until the pop.
            default:  tx_o = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/byte_fifo.sv
// Synchronous FIFO of FIFO_DEPTH entries; the entry type is chosen per instance.
`default_nettype none

module byte_fifo #(
    parameter type entry_t = logic [7:0]
) (
    input  wire logic   clk_i,
    input  wire logic   rst_i,
    input  wire logic   push_i,
    input  wire entry_t push_data_i,
    input  wire logic   pop_i,
    output entry_t      head_o,
    output logic        empty_o,
    output logic        full_o
);

    localparam int AW = uart_pkg::FIFO_AW;

    entry_t mem [uart_pkg::FIFO_DEPTH];

    // The extra pointer bit tells a full queue from an empty one.
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;

    logic do_push;
    logic do_pop;

    assign empty_o = (wr_ptr == rd_ptr);
    assign full_o  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    assign do_push = push_i && !full_o;                // Pushes into a full queue are lost.
    assign do_pop  = pop_i && !empty_o;

    assign head_o = mem[rd_ptr[AW-1:0]];               // Oldest entry, visible without a pop.

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem[wr_ptr[AW-1:0]] <= push_data_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/uart_pkg.sv
// Shared constants, register map and packed types of the UART peripheral; referenced by scope.
`default_nettype none

package uart_pkg;

    localparam int FIFO_DEPTH   = 32;                  // Entries in each queue.
    localparam int FIFO_AW      = $clog2(FIFO_DEPTH);
    localparam int BAUD_W       = 16;
    localparam int TX_STOP_BITS = 2;                   // Stop periods sent per frame.

    localparam logic [BAUD_W-1:0] BAUD_RESET = 16'd15;

    // Word addresses of the register map.
    localparam logic [1:0] ADDR_DATA   = 2'd0;
    localparam logic [1:0] ADDR_STATUS = 2'd1;
    localparam logic [1:0] ADDR_BAUD   = 2'd2;
    localparam logic [1:0] ADDR_CTRL   = 2'd3;

    typedef struct packed {
        logic [1:0]  addr;
        logic        we;                               // Single-cycle write strobe.
        logic        re;                               // Single-cycle read strobe.
        logic [15:0] wdata;
    } bus_req_t;

    // Laid out so that the entry drops straight into bits 8:0 of a DATA read.
    typedef struct packed {
        logic       frame_err;
        logic [7:0] data;
    } rx_entry_t;

    // Fields listed from bit 15 down to bit 0.
    typedef struct packed {
        logic [9:0] zero;
        logic       tx_busy;
        logic       rx_overrun;                        // Sticky until STATUS is read.
        logic       rx_full;
        logic       rx_empty;
        logic       tx_full;
        logic       tx_empty;
    } status_t;

endpackage

`default_nettype wire
